// ==== design/gf_field_pkg.sv ====
package gf_field_pkg;

  localparam int gf_width = 6;

  // GF(4) element, field polynomial x^2 + x + 1
  typedef logic [1:0] gf4_t;

  // Composite GF((2^2)^3) word as three GF(4) digits
  typedef struct packed {
    gf4_t d2;
    gf4_t d1;
    gf4_t d0;
  } gf64_digits_s;

  // Basis maps see a flat vector, the power network sees digits
  typedef union packed {
    logic [gf_width-1:0] flat;
    gf64_digits_s        digit;
  } gf64_word_u;

  function automatic gf4_t gf4_square(gf4_t a);
    return {a[1], a[0] ^ a[1]};
  endfunction

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic t;
    t = a[1] & b[1];
    return {(a[0] & b[1]) ^ (a[1] & b[0]) ^ t, (a[0] & b[0]) ^ t};
  endfunction

  // a^3 is one for any nonzero a, so the product is b or zero
  function automatic gf4_t gf4_scaled_mul(gf4_t a, gf4_t b);
    logic cube;
    cube = a[0] | a[1];
    return {cube & b[1], cube & b[0]};
  endfunction

  // Polynomial basis to composite basis
  function automatic logic [gf_width-1:0] to_composite(logic [gf_width-1:0] a);
    logic [gf_width-1:0] b;
    b[0] = a[0] ^ a[1] ^ a[3] ^ a[4] ^ a[5];
    b[1] = a[2] ^ a[3] ^ a[4] ^ a[5];
    b[2] = a[0] ^ a[1] ^ a[4];
    b[3] = a[1] ^ a[2];
    b[4] = a[0] ^ a[1] ^ a[2] ^ a[3] ^ a[4] ^ a[5];
    b[5] = a[1] ^ a[3] ^ a[4];
    return b;
  endfunction

  function automatic logic [gf_width-1:0] from_composite(logic [gf_width-1:0] a);
    logic [gf_width-1:0] b;
    b[0] = a[0] ^ a[1] ^ a[3];
    b[1] = a[0] ^ a[3] ^ a[4];
    b[2] = a[0] ^ a[4];
    b[3] = a[0] ^ a[1] ^ a[2] ^ a[3] ^ a[5];
    b[4] = a[1] ^ a[2] ^ a[4];
    b[5] = a[1] ^ a[3] ^ a[5];
    return b;
  endfunction

endpackage

// ==== design/sbox_ctrl_pkg.sv ====
package sbox_ctrl_pkg;

  // Register stages between issue and result
  localparam int pipe_latency = 2;

  // Four-phase slave states
  //   idle    waiting for req
  //   busy    word in the pipeline
  //   done    result held, ack high until req drops
  //   release req seen low, ack drops
  typedef enum logic [1:0] {
    hs_idle    = 2'b00,
    hs_busy    = 2'b01,
    hs_done    = 2'b10,
    hs_release = 2'b11
  } hs_state_e;

endpackage

// ==== design/sbox_if.sv ====
`timescale 1ns/100ps

interface sbox_if;

  logic                              issue_valid;
  logic [gf_field_pkg::gf_width-1:0] issue_word;
  logic                              result_valid;
  logic [gf_field_pkg::gf_width-1:0] result_word;

  // Handshake side
  modport front (
    output issue_valid,
    output issue_word,
    input  result_valid,
    input  result_word
  );

  // Datapath side, always ready
  modport pipe (
    input  issue_valid,
    input  issue_word,
    output result_valid,
    output result_word
  );

endinterface

// ==== design/gf64_power26.sv ====
`timescale 1ns/100ps

module gf64_power26 (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     en,
  input  gf_field_pkg::gf64_word_u word_in,
  output gf_field_pkg::gf64_word_u word_out
);

  gf_field_pkg::gf4_t        a0;
  gf_field_pkg::gf4_t        a1;
  gf_field_pkg::gf4_t        a2;
  gf_field_pkg::gf4_t        sq0;
  gf_field_pkg::gf4_t        sq1;
  gf_field_pkg::gf4_t        sq2;
  gf_field_pkg::gf4_t [14:0] term_d;
  gf_field_pkg::gf4_t [14:0] term_q;
  gf_field_pkg::gf4_t        sum0;
  gf_field_pkg::gf4_t        sum1;
  gf_field_pkg::gf4_t        sum2;
  gf_field_pkg::gf64_word_u  word_d;

  assign a0 = word_in.digit.d0;
  assign a1 = word_in.digit.d1;
  assign a2 = word_in.digit.d2;

  assign sq0 = gf_field_pkg::gf4_square(a0);
  assign sq1 = gf_field_pkg::gf4_square(a1);
  assign sq2 = gf_field_pkg::gf4_square(a2);

  always_comb begin
    term_d[0]  = sq0;
    term_d[1]  = sq1;
    term_d[2]  = sq2;
    // Cross terms scaled by the cube of the other digit
    term_d[3]  = gf_field_pkg::gf4_scaled_mul(a1, sq0);
    term_d[4]  = gf_field_pkg::gf4_scaled_mul(a2, sq0);
    term_d[5]  = gf_field_pkg::gf4_scaled_mul(a0, sq1);
    term_d[6]  = gf_field_pkg::gf4_scaled_mul(a2, sq1);
    term_d[7]  = gf_field_pkg::gf4_scaled_mul(a0, sq2);
    term_d[8]  = gf_field_pkg::gf4_scaled_mul(a1, sq2);
    term_d[9]  = gf_field_pkg::gf4_mul(a0, a1);
    term_d[10] = gf_field_pkg::gf4_mul(a0, a2);
    term_d[11] = gf_field_pkg::gf4_mul(a1, a2);
    // One digit times the product of the other two squares
    term_d[12] = gf_field_pkg::gf4_mul(a0, gf_field_pkg::gf4_mul(sq1, sq2));
    term_d[13] = gf_field_pkg::gf4_mul(a1, gf_field_pkg::gf4_mul(sq0, sq2));
    term_d[14] = gf_field_pkg::gf4_mul(a2, gf_field_pkg::gf4_mul(sq0, sq1));
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      term_q <= '0;
    end else if (en) begin
      term_q <= term_d;
    end
  end

  // Digit sums, nine terms each
  assign sum0 = term_q[1] ^ term_q[2] ^ term_q[4] ^ term_q[5] ^ term_q[6] ^
                term_q[9] ^ term_q[11] ^ term_q[12] ^ term_q[13];
  assign sum1 = term_q[0] ^ term_q[2] ^ term_q[5] ^ term_q[7] ^ term_q[8] ^
                term_q[10] ^ term_q[11] ^ term_q[13] ^ term_q[14];
  assign sum2 = gf_field_pkg::gf4_add(term_q[0] ^ term_q[1] ^ term_q[3] ^ term_q[4],
                term_q[8] ^ term_q[9] ^ term_q[10] ^ term_q[12] ^ term_q[14]);

  always_comb begin
    word_d.digit.d0 = sum0;
    word_d.digit.d1 = sum1;
    word_d.digit.d2 = sum2;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      word_out <= '0;
    end else if (en) begin
      word_out <= word_d;
    end
  end

endmodule

// ==== design/sbox_pipeline.sv ====
`timescale 1ns/100ps

module sbox_pipeline (
  input logic   clk,
  input logic   arst_n,
  sbox_if.pipe  bus
);

  localparam int lat = sbox_ctrl_pkg::pipe_latency;

  gf_field_pkg::gf64_word_u composite_in;
  gf_field_pkg::gf64_word_u composite_out;
  logic [lat-1:0]           valid_sr;
  logic                     stage_en;

  assign composite_in.flat = gf_field_pkg::to_composite(bus.issue_word);

  // Clock the network only while a word moves through it
  assign stage_en = bus.issue_valid | valid_sr[0];

  gf64_power26 power_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .en       (stage_en),
    .word_in  (composite_in),
    .word_out (composite_out)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[lat-2:0], bus.issue_valid};
    end
  end

  // Inverse map sits after the second register
  assign bus.result_word  = gf_field_pkg::from_composite(composite_out.flat);
  assign bus.result_valid = valid_sr[lat-1];

  // Every result traces back to an issue exactly lat cycles before
  a_result_from_issue: assert property (
    @(posedge clk) disable iff (!arst_n)
    bus.result_valid |-> $past(bus.issue_valid, lat)
  );

endmodule

// ==== design/sbox_handshake.sv ====
`timescale 1ns/100ps

module sbox_handshake (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req,
  input  logic [gf_field_pkg::gf_width-1:0] data_in,
  output logic                              ack,
  output logic [gf_field_pkg::gf_width-1:0] data_out,
  sbox_if.front                             bus
);

  sbox_ctrl_pkg::hs_state_e state;
  logic                     launch;

  // New transaction only once the previous ack has fallen
  assign launch = (state == sbox_ctrl_pkg::hs_idle) && req && !ack;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state           <= sbox_ctrl_pkg::hs_idle;
      ack             <= 1'b0;
      bus.issue_valid <= 1'b0;
      data_out        <= '0;
    end else begin
      bus.issue_valid <= launch;
      case (state)
        sbox_ctrl_pkg::hs_idle: begin
          if (launch) begin
            state <= sbox_ctrl_pkg::hs_busy;
          end
        end
        sbox_ctrl_pkg::hs_busy: begin
          if (bus.result_valid) begin
            data_out <= bus.result_word;
            state    <= sbox_ctrl_pkg::hs_done;
          end
        end
        sbox_ctrl_pkg::hs_done: begin
          ack <= 1'b1;
          if (ack && !req) begin
            state <= sbox_ctrl_pkg::hs_release;
          end
        end
        sbox_ctrl_pkg::hs_release: begin
          ack   <= 1'b0;
          state <= sbox_ctrl_pkg::hs_idle;
        end
        default: state <= sbox_ctrl_pkg::hs_idle;
      endcase
    end
  end

  // Input word is held for the pipeline from the launch edge on
  always_ff @(posedge clk) begin
    if (launch) begin
      bus.issue_word <= data_in;
    end
  end

  a_issue_from_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    bus.issue_valid |-> $past(state == sbox_ctrl_pkg::hs_idle)
  );

  // Pipeline answers while we are still waiting for it
  a_issue_returns: assert property (
    @(posedge clk) disable iff (!arst_n)
    bus.issue_valid |-> ##(sbox_ctrl_pkg::pipe_latency)
      (bus.result_valid && state == sbox_ctrl_pkg::hs_busy)
  );

  a_result_in_busy: assert property (
    @(posedge clk) disable iff (!arst_n)
    bus.result_valid |-> state == sbox_ctrl_pkg::hs_busy
  );

  a_ack_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    (ack && req) |=> ack
  );

endmodule

// ==== design/sbox_unit.sv ====
`timescale 1ns/100ps

module sbox_unit (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req,
  input  logic [gf_field_pkg::gf_width-1:0] data_in,
  output logic                              ack,
  output logic [gf_field_pkg::gf_width-1:0] data_out
);

  sbox_if bus_if ();

  sbox_handshake handshake_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .data_in  (data_in),
    .ack      (ack),
    .data_out (data_out),
    .bus      (bus_if.front)
  );

  // x^26 datapath, two register stages
  sbox_pipeline pipeline_i (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (bus_if.pipe)
  );

endmodule

// ==== verification/sbox_unit_tb.sv ====
`timescale 1ns/100ps

module sbox_unit_tb;

  localparam int entries      = 64;
  localparam int rise_latency = 4;
  localparam int fall_latency = 1;
  localparam int rise_limit   = 16;
  localparam int fall_limit   = 8;

  logic                              clk;
  logic                              arst_n;
  logic                              req;
  logic [gf_field_pkg::gf_width-1:0] data_in;
  logic                              ack;
  logic [gf_field_pkg::gf_width-1:0] data_out;

  // Even slots hold the input word, odd slots the expected x^26
  logic [gf_field_pkg::gf_width-1:0] golden_mem [0:2*entries-1];
  int                                order [0:entries-1];

  sbox_unit sbox_unit_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .data_in  (data_in),
    .ack      (ack),
    .data_out (data_out)
  );

  always #4 clk = ~clk;

  task automatic stop_run(string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      stop_run($sformatf("CHECK FAILED at %0t: %s expected %0h actual %0h",
                         $time, name, expected, actual));
    end
  endtask

  // Counts edges after the one that samples the new req level
  task automatic wait_for_ack(logic level, int limit, string phase, output int cycles);
    @(posedge clk);
    #1;
    cycles = 0;
    while (ack !== level) begin
      if (cycles >= limit) begin
        stop_run($sformatf("Timeout at %0t: ack did not %s within %0d cycles",
                           $time, phase, limit));
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  task automatic idle_cycles(int count, logic [gf_field_pkg::gf_width-1:0] held);
    repeat (count) begin
      @(posedge clk);
      #1;
      check_value("ack", 0, 32'(ack));
      check_value("data_out", 32'(held), 32'(data_out));
    end
  endtask

  task automatic run_transaction(int idx, int hold);
    logic [gf_field_pkg::gf_width-1:0] word;
    logic [gf_field_pkg::gf_width-1:0] expected;
    int                                cycles;
    word     = golden_mem[2*idx];
    expected = golden_mem[2*idx+1];
    data_in  = word;
    req      = 1'b1;
    wait_for_ack(1'b1, rise_limit, "rise after req went high", cycles);
    check_value("ack rise cycles", rise_latency, cycles);
    check_value("data_out", 32'(expected), 32'(data_out));
    // Master keeps req up, so the slave has to sit on the same result
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_value("ack", 1, 32'(ack));
      check_value("data_out", 32'(expected), 32'(data_out));
    end
    req     = 1'b0;
    data_in = 6'($urandom);
    wait_for_ack(1'b0, fall_limit, "fall after req went low", cycles);
    check_value("ack fall cycles", fall_latency, cycles);
    check_value("data_out", 32'(expected), 32'(data_out));
  endtask

  initial begin
    int gap;
    int j;
    int tmp;
    int prev;
    clk     = 1'b0;
    arst_n  = 1'b0;
    req     = 1'b0;
    data_in = '0;
    void'($urandom(32'hd01d));
    $readmemh("verification/sbox_golden.hex", golden_mem);
    if ($isunknown(golden_mem[2*entries-1])) begin
      stop_run("Golden file verification/sbox_golden.hex is missing or too short");
    end
    for (int i = 0; i < entries; i++) begin
      check_value("golden input column", i, 32'(golden_mem[2*i]));
    end
    check_value("golden image of 0", 0, 32'(golden_mem[1]));
    check_value("golden image of 1", 1, 32'(golden_mem[3]));

    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    idle_cycles(3, '0);

    // File order, back to back, some requests held long after ack
    for (int i = 0; i < entries; i++) begin
      run_transaction(i, (i % 8 == 3) ? 5 : 0);
    end

    for (int i = 0; i < entries; i++) begin
      order[i] = i;
    end
    for (int i = entries - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end

    prev = entries - 1;
    for (int i = 0; i < entries; i++) begin
      gap = int'($urandom % 4);
      idle_cycles(gap, golden_mem[2*prev+1]);
      run_transaction(order[i], 0);
      prev = order[i];
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verification/sbox_golden.hex ====
// input expected, both hex, one pair per line
// expected = input^26 in GF(2^6) with field polynomial x^6 + x + 1
00 00
01 01
02 07
03 33
04 15
05 39
06 1F
07 32
08 28
09 0A
0A 29
0B 1C
0C 1E
0D 2B
0E 18
0F 0E
10 1D
11 3E
12 36
13 1B
14 1A
15 38
16 17
17 0F
18 19
19 16
1A 14
1B 37
1C 0B
1D 3F
1E 2A
1F 06
20 10
21 2C
22 3C
23 24
24 04
25 34
26 02
27 22
28 05
29 25
2A 2E
2B 08
2C 26
2D 30
2E 2D
2F 09
30 0C
31 23
32 21
33 11
34 2F
35 20
36 03
37 27
38 31
39 0D
3A 3B
3B 3A
3C 13
3D 35
3E 12
3F 3D

// ==== verilog.f ====
design/gf_field_pkg.sv
design/sbox_ctrl_pkg.sv
design/sbox_if.sv
design/gf64_power26.sv
design/sbox_pipeline.sv
design/sbox_handshake.sv
design/sbox_unit.sv
verification/sbox_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sbox_unit_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
